//--- logic/crc_defines.svh
`ifndef CRC_DEFINES_SVH
`define CRC_DEFINES_SVH

//////////////////////////////////////////////////
// Data buffer sizing
//////////////////////////////////////////////////

// Beats held between the bus side and the datapath
`define CRC_BUFFER_DEPTH 4

//////////////////////////////////////////////////
// Register map, offsets decoded from HADDR[4:2]
//////////////////////////////////////////////////

// Data in on write, finished CRC on read
`define CRC_ADDR_DR   3'd0
// 8-bit scratch register
`define CRC_ADDR_IDR  3'd1
// Control, fields at bits 7:3, reset-chain strobe at bit 0
`define CRC_ADDR_CR   3'd2
`define CRC_ADDR_INIT 3'd4
`define CRC_ADDR_POL  3'd5

// Control fields after reset: 32-bit poly, no reversal
`define CRC_CR_RESET  5'h00

`endif

//--- logic/ahb_bus_pkg.sv
package ahb_bus_pkg;

	//////////////////////////////////////////////////
	// AHB-Lite encodings
	//////////////////////////////////////////////////

	// HTRANS values
	// Only NONSEQ starts a transfer here, BUSY and SEQ are ignored
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// HRESP values
	// The slave never answers with ERROR
	typedef enum logic
	{
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	//////////////////////////////////////////////////
	// Address phase as held through the data phase
	//////////////////////////////////////////////////

	typedef struct packed
	{
		logic [2:0] offset;   // HADDR[4:2]
		logic [2:0] size;     // HSIZE
		htrans_e    trans;
		logic       write;
		logic       sel;
	} ahb_addr_phase_t;

endpackage

//--- logic/crc_core_pkg.sv
package crc_core_pkg;

	// Polynomial width selected in CR[4:3]
	typedef enum logic [1:0]
	{
		POLY_32 = 2'b00,
		POLY_16 = 2'b01,
		POLY_8  = 2'b10,
		POLY_7  = 2'b11
	} poly_size_e;

	// Input bit reversal selected in CR[6:5]
	typedef enum logic [1:0]
	{
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_e;

	// Beat width, low bits of HSIZE
	typedef enum logic [1:0]
	{
		BEAT_BYTE = 2'b00,
		BEAT_HALF = 2'b01,
		BEAT_WORD = 2'b10
	} beat_size_e;

	// Field order matches CR bits 7:3
	typedef struct packed
	{
		logic       rev_out;
		rev_in_e    rev_in;
		poly_size_e poly_size;
	} crc_cfg_t;

	// One data register write
	typedef struct packed
	{
		logic [31:0] data;
		beat_size_e  size;
	} crc_beat_t;

	// Register writes towards the datapath
	typedef struct packed
	{
		logic        init_en;
		logic        idr_en;
		logic        pol_en;
		logic        reset_chain;
		logic [31:0] data;
	} crc_wr_t;

	// Read-back values from the datapath
	typedef struct packed
	{
		logic [31:0] crc;
		logic [31:0] init;
		logic [31:0] pol;
		logic [7:0]  idr;
	} crc_rd_t;

endpackage

//--- logic/host_interface.sv
`include "crc_defines.svh"

module host_interface import ahb_bus_pkg::*, crc_core_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  htrans_e     HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	input  logic        buffer_full,
	input  logic        buffer_empty,
	input  logic        crc_busy,
	input  crc_rd_t     crc_rd,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output hresp_e      HRESP,
	output crc_beat_t   beat_in,
	output logic        buffer_write_en,
	output crc_wr_t     crc_wr,
	output crc_cfg_t    crc_cfg
);

// Address phase held for the data phase
ahb_addr_phase_t ap;
// Control register fields
crc_cfg_t cfg_q;

logic sample_bus;
logic xfer;
logic write_en;
logic read_en;
logic read_wait;
logic dr_sel;
logic idr_sel;
logic cr_sel;
logic init_sel;
logic pol_sel;
logic dr_write;
logic dr_read;
logic cfg_write;
logic cr_commit;
logic [31:0] cr_rd;

//////////////////////////////////////////////////
// Address phase pipeline
//////////////////////////////////////////////////

// New address phase only when the previous data phase ends
assign sample_bus = HREADY && HREADYOUT;

always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		ap <= '0;
	end
	else if (sample_bus)
	begin
		ap.offset <= HADDR[4:2];
		ap.size   <= HSIZE;
		ap.trans  <= HTRANS;
		ap.write  <= HWRITE;
		ap.sel    <= HSEL;
	end
end

// Selected NONSEQ only
assign xfer     = ap.sel && (ap.trans == NONSEQ);
assign write_en = xfer && ap.write;
assign read_en  = xfer && !ap.write;

// Register decode
assign dr_sel   = (ap.offset == `CRC_ADDR_DR);
assign idr_sel  = (ap.offset == `CRC_ADDR_IDR);
assign cr_sel   = (ap.offset == `CRC_ADDR_CR);
assign init_sel = (ap.offset == `CRC_ADDR_INIT);
assign pol_sel  = (ap.offset == `CRC_ADDR_POL);

assign dr_write  = dr_sel && write_en;
assign dr_read   = dr_sel && read_en;
assign cfg_write = (init_sel || pol_sel || cr_sel) && write_en;

// Beats still queued or being folded in
assign read_wait = !buffer_empty || crc_busy;

//////////////////////////////////////////////////
// Wait states and write strobes
//////////////////////////////////////////////////

// Full buffer holds a DR write, pending work holds DR reads and config writes
assign HREADYOUT = !((dr_write && buffer_full) || ((dr_read || cfg_write) && read_wait));
assign HRESP     = OKAY;

// Write data comes straight from the data phase
assign beat_in.data    = HWDATA;
assign beat_in.size    = beat_size_e'(ap.size[1:0]);
assign buffer_write_en = dr_write && !buffer_full;

// Strobes fire only on the cycle the data phase completes
assign cr_commit = cr_sel && write_en && !read_wait;

always_comb
begin
	crc_wr.init_en     = init_sel && write_en && !read_wait;
	crc_wr.pol_en      = pol_sel && write_en && !read_wait;
	crc_wr.idr_en      = idr_sel && write_en;
	// Bit 0 self clears, it is never stored
	crc_wr.reset_chain = cr_commit && HWDATA[0];
	crc_wr.data        = HWDATA;
end

// Control register
always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		cfg_q <= crc_cfg_t'(`CRC_CR_RESET);
	end
	else if (cr_commit)
	begin
		cfg_q <= crc_cfg_t'(HWDATA[7:3]);
	end
end

assign crc_cfg = cfg_q;

//////////////////////////////////////////////////
// Read data
//////////////////////////////////////////////////

// Fields read back where they were written, reset bit reads zero
assign cr_rd = {24'h0, cfg_q, 3'h0};

always_comb
begin
	case (ap.offset)
		`CRC_ADDR_DR:   HRDATA = crc_rd.crc;
		`CRC_ADDR_IDR:  HRDATA = {24'h0, crc_rd.idr};
		`CRC_ADDR_CR:   HRDATA = cr_rd;
		`CRC_ADDR_INIT: HRDATA = crc_rd.init;
		`CRC_ADDR_POL:  HRDATA = crc_rd.pol;
		default:        HRDATA = '0;
	endcase
end

// Every strobe traces back to a selected NONSEQ write
a_strobe_needs_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
	(buffer_write_en || crc_wr.init_en || crc_wr.idr_en || crc_wr.pol_en || crc_wr.reset_chain)
	|-> (ap.sel && ap.write && (ap.trans == NONSEQ)));

// Stalled DR read ends once the buffer and datapath drain
a_dr_read_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
	(dr_read && !HREADYOUT) |-> ##[0:40] HREADYOUT);

endmodule

//--- logic/crc_data_buffer.sv
`include "crc_defines.svh"

module crc_data_buffer import crc_core_pkg::*;
(
	input  logic      HCLK,
	input  logic      HRESETn,
	input  crc_beat_t beat_in,
	input  logic      buffer_write_en,
	input  logic      beat_ack,
	output logic      buffer_full,
	output logic      buffer_empty,
	output crc_beat_t beat_out,
	output logic      beat_req
);

localparam int DEPTH = `CRC_BUFFER_DEPTH;
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

crc_beat_t mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic pop;

// Circular pointer step
function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
	return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

// Beat leaves when the datapath acknowledges it
assign pop = beat_req && beat_ack;

assign buffer_full  = (count == CNT_W'(DEPTH));
assign buffer_empty = (count == '0);
// Head entry, rd_ptr holds still while req is up
assign beat_out     = mem[rd_ptr];

// Storage
always_ff @(posedge HCLK)
begin
	if (buffer_write_en)
	begin
		mem[wr_ptr] <= beat_in;
	end
end

//////////////////////////////////////////////////
// Pointers, occupancy and req/ack sequencer
//////////////////////////////////////////////////

always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		wr_ptr   <= '0;
		rd_ptr   <= '0;
		count    <= '0;
		beat_req <= 1'b0;
	end
	else
	begin
		if (buffer_write_en)
		begin
			wr_ptr <= ptr_next(wr_ptr);
		end
		if (pop)
		begin
			rd_ptr <= ptr_next(rd_ptr);
		end
		case ({buffer_write_en, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
		// Drop on ack, raise again only once ack has fallen
		if (pop)
		begin
			beat_req <= 1'b0;
		end
		else if (!beat_req && !beat_ack && !buffer_empty)
		begin
			beat_req <= 1'b1;
		end
	end
end

// Host side must hold off while full
a_no_write_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
	buffer_write_en |-> !buffer_full);

// Offered beat holds until it is taken
a_beat_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
	(beat_req && $past(beat_req)) |-> $stable(beat_out));

endmodule

//--- logic/crc_datapath.sv
module crc_datapath import crc_core_pkg::*;
(
	input  logic      HCLK,
	input  logic      HRESETn,
	input  crc_beat_t beat_out,
	input  logic      beat_req,
	input  crc_wr_t   crc_wr,
	input  crc_cfg_t  crc_cfg,
	output logic      beat_ack,
	output logic      crc_busy,
	output crc_rd_t   crc_rd
);

// Ethernet polynomial after reset
localparam logic [31:0] POL_RESET = 32'h04C1_1DB7;

logic [31:0] pol_q;
logic [31:0] init_q;
logic [31:0] crc_q;
logic [7:0]  idr_q;
// Beat bytes, next one at the top
logic [31:0] shift_q;
logic [2:0]  bytes_left;
logic [2:0]  beat_bytes;
logic [5:0]  width;
logic [5:0]  shift_amt;
logic [31:0] width_mask;
logic [31:0] word_rev;
logic [31:0] data_rev;
logic [31:0] data_aligned;
logic [31:0] crc_next;
logic [31:0] crc_masked;
logic capture;

function automatic logic [31:0] bit_reverse(input logic [31:0] v);
	logic [31:0] r;
	for (int i = 0; i < 32; i++)
	begin
		r[i] = v[31 - i];
	end
	return r;
endfunction

// One byte, MSB first, CRC left aligned in 32 bits
function automatic logic [31:0] crc_byte_step(input logic [31:0] crc, input logic [7:0] din,
	input logic [31:0] poly, input logic [5:0] shift);
	logic [31:0] acc;
	logic [31:0] pol_al;
	acc    = (crc << shift) ^ {din, 24'h0};
	pol_al = poly << shift;
	for (int i = 0; i < 8; i++)
	begin
		acc = acc[31] ? ((acc << 1) ^ pol_al) : (acc << 1);
	end
	return acc >> shift;
endfunction

//////////////////////////////////////////////////
// Width and input shaping
//////////////////////////////////////////////////

always_comb
begin
	case (crc_cfg.poly_size)
		POLY_16: width = 6'd16;
		POLY_8:  width = 6'd8;
		POLY_7:  width = 6'd7;
		default: width = 6'd32;
	endcase
end

assign shift_amt  = 6'd32 - width;
assign width_mask = 32'hFFFF_FFFF >> shift_amt;

// Byte and halfword reversal are swaps of the full word reversal
always_comb
begin
	word_rev = bit_reverse(beat_out.data);
	case (crc_cfg.rev_in)
		REV_BYTE: data_rev = {word_rev[7:0], word_rev[15:8], word_rev[23:16], word_rev[31:24]};
		REV_HALF: data_rev = {word_rev[15:0], word_rev[31:16]};
		REV_WORD: data_rev = word_rev;
		default:  data_rev = beat_out.data;
	endcase
end

// Low bytes of a short beat moved to the top
always_comb
begin
	case (beat_out.size)
		BEAT_BYTE:
		begin
			data_aligned = {data_rev[7:0], 24'h0};
			beat_bytes   = 3'd1;
		end
		BEAT_HALF:
		begin
			data_aligned = {data_rev[15:0], 16'h0};
			beat_bytes   = 3'd2;
		end
		default:
		begin
			data_aligned = data_rev;
			beat_bytes   = 3'd4;
		end
	endcase
end

//////////////////////////////////////////////////
// Handshake and byte sequencing
//////////////////////////////////////////////////

// Take a new beat only when idle and the last ack has fallen
assign capture = beat_req && !beat_ack && !crc_busy;

always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		beat_ack   <= 1'b0;
		crc_busy   <= 1'b0;
		bytes_left <= '0;
	end
	else if (capture)
	begin
		beat_ack   <= 1'b1;
		crc_busy   <= 1'b1;
		bytes_left <= beat_bytes;
	end
	else
	begin
		// Ack falls once req has
		if (beat_ack && !beat_req)
		begin
			beat_ack <= 1'b0;
		end
		if (crc_busy)
		begin
			bytes_left <= bytes_left - 1'b1;
			crc_busy   <= (bytes_left != 3'd1);
		end
	end
end

always_ff @(posedge HCLK)
begin
	if (capture)
	begin
		shift_q <= data_aligned;
	end
	else if (crc_busy)
	begin
		shift_q <= shift_q << 8;
	end
end

assign crc_next = crc_byte_step(crc_q, shift_q[31:24], pol_q, shift_amt);

// CRC and programmable registers
always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		crc_q  <= '1;
		init_q <= '1;
		pol_q  <= POL_RESET;
		idr_q  <= '0;
	end
	else
	begin
		if (crc_wr.reset_chain)
		begin
			crc_q <= init_q;
		end
		else if (crc_busy)
		begin
			crc_q <= crc_next;
		end
		if (crc_wr.init_en)
		begin
			init_q <= crc_wr.data;
		end
		if (crc_wr.pol_en)
		begin
			pol_q <= crc_wr.data;
		end
		if (crc_wr.idr_en)
		begin
			idr_q <= crc_wr.data[7:0];
		end
	end
end

// Result trimmed to width, optionally mirrored within it
assign crc_masked = crc_q & width_mask;

always_comb
begin
	crc_rd.crc  = crc_cfg.rev_out ? (bit_reverse(crc_masked) >> shift_amt) : crc_masked;
	crc_rd.init = init_q;
	crc_rd.pol  = pol_q;
	crc_rd.idr  = idr_q;
end

// Four-phase order, req only drops while ack is still up
a_ack_after_req: assert property (@(posedge HCLK) disable iff (!HRESETn)
	$fell(beat_req) |-> beat_ack);

// Host stalls config writes until the datapath is idle
a_no_cfg_busy: assert property (@(posedge HCLK) disable iff (!HRESETn)
	(crc_wr.init_en || crc_wr.pol_en || crc_wr.reset_chain) |-> !crc_busy);

endmodule

//--- logic/crc_ahb_top.sv
module crc_ahb_top import ahb_bus_pkg::*, crc_core_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSEL,
	input  logic [31:0] HADDR,
	input  htrans_e     HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output hresp_e      HRESP
);

// Host to buffer
crc_beat_t beat_in;
logic buffer_write_en;
logic buffer_full;
logic buffer_empty;
// Buffer to datapath, four-phase
crc_beat_t beat_out;
logic beat_req;
logic beat_ack;
// Datapath status and registers
logic crc_busy;
crc_wr_t crc_wr;
crc_rd_t crc_rd;
crc_cfg_t crc_cfg;

host_interface u_host (.HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR),
	.HTRANS(HTRANS), .HWRITE(HWRITE), .HSIZE(HSIZE), .HWDATA(HWDATA), .HREADY(HREADY),
	.buffer_full(buffer_full), .buffer_empty(buffer_empty), .crc_busy(crc_busy),
	.crc_rd(crc_rd), .HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP),
	.beat_in(beat_in), .buffer_write_en(buffer_write_en), .crc_wr(crc_wr), .crc_cfg(crc_cfg));

crc_data_buffer u_buffer (.HCLK(HCLK), .HRESETn(HRESETn), .beat_in(beat_in),
	.buffer_write_en(buffer_write_en), .beat_ack(beat_ack), .buffer_full(buffer_full),
	.buffer_empty(buffer_empty), .beat_out(beat_out), .beat_req(beat_req));

crc_datapath u_datapath (.HCLK(HCLK), .HRESETn(HRESETn), .beat_out(beat_out),
	.beat_req(beat_req), .crc_wr(crc_wr), .crc_cfg(crc_cfg), .beat_ack(beat_ack),
	.crc_busy(crc_busy), .crc_rd(crc_rd));

endmodule

//--- verif/crc_ref_model.svh
`ifndef CRC_REF_MODEL_SVH
`define CRC_REF_MODEL_SVH

//////////////////////////////////////////////////
// Stimulus source
//////////////////////////////////////////////////

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

//////////////////////////////////////////////////
// Reference CRC, bit serial
//////////////////////////////////////////////////

// CR[4:3] code to polynomial width
function automatic int poly_width(input logic [1:0] code);
	case (code)
		2'd1: return 16;
		2'd2: return 8;
		2'd3: return 7;
		default: return 32;
	endcase
endfunction

function automatic logic [31:0] low_mask(input int w);
	return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 1);
endfunction

// Mirror bits inside each lane of 8, 16 or 32 bits
function automatic logic [31:0] mirror_lanes(input logic [31:0] d, input logic [1:0] code);
	logic [31:0] r;
	int lw;
	if (code == 2'd0)
		return d;
	lw = 4 << code;
	for (int i = 0; i < 32; i++)
		r[(i / lw) * lw + (lw - 1 - (i % lw))] = d[i];
	return r;
endfunction

// One beat, bytes of the low end sent MSB first; cfg is CR[7:3]
function automatic logic [31:0] ref_crc_beat(input logic [31:0] crc, input logic [31:0] data,
	input logic [1:0] size, input logic [4:0] cfg, input logic [31:0] poly);
	int w;
	int nbytes;
	logic [31:0] m;
	logic [31:0] d;
	logic [31:0] c;
	logic fb;
	w      = poly_width(cfg[1:0]);
	m      = low_mask(w);
	d      = mirror_lanes(data, cfg[3:2]);
	nbytes = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
	c      = crc & m;
	for (int b = nbytes - 1; b >= 0; b--)
		for (int k = 7; k >= 0; k--)
		begin
			fb = c[w - 1] ^ d[b * 8 + k];
			c  = (c << 1) & m;
			if (fb)
				c = c ^ (poly & m);
		end
	return c;
endfunction

// DR read value, masked and optionally mirrored within the width
function automatic logic [31:0] ref_crc_read(input logic [31:0] crc, input logic [4:0] cfg);
	int w;
	logic [31:0] c;
	logic [31:0] r;
	w = poly_width(cfg[1:0]);
	c = crc & low_mask(w);
	r = '0;
	if (!cfg[4])
		return c;
	for (int i = 0; i < w; i++)
		r[i] = c[w - 1 - i];
	return r;
endfunction

`endif

//--- verif/crc_ahb_tb.sv
`include "crc_defines.svh"

module crc_ahb_tb
	import ahb_bus_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

`include "crc_ref_model.svh"

localparam logic [2:0] SZ_B = 3'd0;
localparam logic [2:0] SZ_H = 3'd1;
localparam logic [2:0] SZ_W = 3'd2;

// One table entry
typedef struct packed
{
	logic        is_write;
	logic [2:0]  offset;
	logic [2:0]  size;
	logic [31:0] data;
	logic [31:0] expected;
	logic        rnd;      // data taken from the LFSR
	logic        use_ref;  // expected taken from the reference CRC
} test_row_t;

logic        HCLK;
logic        HRESETn;
logic        HSEL;
logic [31:0] HADDR;
htrans_e     HTRANS;
logic        HWRITE;
logic [2:0]  HSIZE;
logic [31:0] HWDATA;
logic        HREADY;
logic [31:0] HRDATA;
logic        HREADYOUT;
hresp_e      HRESP;

test_row_t   rows[$];
int          cycles = 0;
int          limit = 100;
int          errors = 0;
int          rows_failed = 0;
logic [15:0] lfsr_state;
// Register model
logic [31:0] m_crc;
logic [31:0] m_init;
logic [31:0] m_pol;
logic [4:0]  m_cfg;

crc_ahb_top u_crc_ahb_top (.HCLK(HCLK), .HRESETn(HRESETn), .HSEL(HSEL), .HADDR(HADDR),
	.HTRANS(HTRANS), .HWRITE(HWRITE), .HSIZE(HSIZE), .HWDATA(HWDATA), .HREADY(HREADY),
	.HRDATA(HRDATA), .HREADYOUT(HREADYOUT), .HRESP(HRESP));

initial
begin
	HCLK = 1'b0;
	forever #50 HCLK = ~HCLK;
end

// Run limit, set from the table length at time zero
initial
begin
	@(posedge HCLK);
	while (cycles < limit)
	begin
		@(posedge HCLK);
		cycles++;
	end
	$display("Timeout after %0d cycles, the DUT never finished a transfer", limit);
	$display("Test failures found");
	$finish;
end

//////////////////////////////////////////////////
// Table building
//////////////////////////////////////////////////

task add_write(input logic [2:0] off, input logic [2:0] sz, input logic [31:0] d, input logic r);
	rows.push_back('{1'b1, off, sz, d, 32'h0, r, 1'b0});
endtask

task add_read(input logic [2:0] off, input logic [31:0] e, input logic use_ref);
	rows.push_back('{1'b0, off, SZ_W, 32'h0, e, 1'b0, use_ref});
endtask

task add_random_words(input int n);
	for (int i = 0; i < n; i++)
		add_write(`CRC_ADDR_DR, SZ_W, 32'h0, 1'b1);
endtask

task build_table;
	// Reset values
	add_read(`CRC_ADDR_INIT, 32'hFFFF_FFFF, 1'b0);
	add_read(`CRC_ADDR_POL, 32'h04C1_1DB7, 1'b0);
	add_read(`CRC_ADDR_IDR, 32'h0, 1'b0);
	add_read(`CRC_ADDR_CR, 32'h0, 1'b0);
	add_read(`CRC_ADDR_DR, 32'hFFFF_FFFF, 1'b0);
	// Default 32-bit poly, word beats
	add_random_words(3);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	// IDR keeps 8 bits, CR fields at 7:3
	add_write(`CRC_ADDR_IDR, SZ_W, 32'h1234_ABCD, 1'b0);
	add_read(`CRC_ADDR_IDR, 32'h0000_00CD, 1'b0);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_00F9, 1'b0);
	add_read(`CRC_ADDR_CR, 32'h0000_00F8, 1'b0);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	// 16-bit poly
	add_write(`CRC_ADDR_INIT, SZ_W, 32'h0000_FFFF, 1'b0);
	add_write(`CRC_ADDR_POL, SZ_W, 32'h0000_1021, 1'b0);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0009, 1'b0);
	add_write(`CRC_ADDR_DR, SZ_B, 32'h0, 1'b1);
	add_write(`CRC_ADDR_DR, SZ_H, 32'h0, 1'b1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	// 8-bit poly
	add_write(`CRC_ADDR_INIT, SZ_W, 32'h0, 1'b0);
	add_write(`CRC_ADDR_POL, SZ_W, 32'h0000_0007, 1'b0);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0011, 1'b0);
	add_write(`CRC_ADDR_DR, SZ_B, 32'h0, 1'b1);
	add_write(`CRC_ADDR_DR, SZ_H, 32'h0, 1'b1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	// 7-bit poly
	add_write(`CRC_ADDR_POL, SZ_W, 32'h0000_0009, 1'b0);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0019, 1'b0);
	add_write(`CRC_ADDR_DR, SZ_B, 32'h0, 1'b1);
	add_write(`CRC_ADDR_DR, SZ_H, 32'h0, 1'b1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	// Input reversal by byte, halfword, word, then output reversal
	add_write(`CRC_ADDR_INIT, SZ_W, 32'hFFFF_FFFF, 1'b0);
	add_write(`CRC_ADDR_POL, SZ_W, 32'h04C1_1DB7, 1'b0);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0021, 1'b0);
	add_random_words(1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0041, 1'b0);
	add_random_words(1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0061, 1'b0);
	add_random_words(1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_00E1, 1'b0);
	add_random_words(1);
	add_write(`CRC_ADDR_DR, SZ_H, 32'h0, 1'b1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0081, 1'b0);
	add_write(`CRC_ADDR_DR, SZ_B, 32'h0, 1'b1);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	// Overfill the buffer, then restart the chain
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0001, 1'b0);
	add_random_words(6);
	add_read(`CRC_ADDR_DR, 32'h0, 1'b1);
	add_write(`CRC_ADDR_CR, SZ_W, 32'h0000_0001, 1'b0);
	add_read(`CRC_ADDR_DR, 32'hFFFF_FFFF, 1'b0);
endtask

//////////////////////////////////////////////////
// AHB driver, entered and left just after a rising edge
//////////////////////////////////////////////////

task drive_address(input logic is_write, input logic [2:0] off, input logic [2:0] sz);
	#10;
	HSEL   = 1'b1;
	HADDR  = {27'h0, off, 2'b00};
	HTRANS = NONSEQ;
	HWRITE = is_write;
	HSIZE  = sz;
	@(posedge HCLK);
	#10;
	// Bus idle behind the data phase
	HSEL   = 1'b0;
	HTRANS = IDLE;
	HWRITE = 1'b0;
endtask

// Outputs read mid-cycle, data phase ends on the next edge
task finish_data_phase(output logic [31:0] rdata, output hresp_e resp);
	@(negedge HCLK);
	while (!HREADYOUT)
		@(negedge HCLK);
	rdata = HRDATA;
	resp  = HRESP;
	@(posedge HCLK);
endtask

task ahb_write(input logic [2:0] off, input logic [2:0] sz, input logic [31:0] d,
	output hresp_e resp);
	logic [31:0] unused;
	drive_address(1'b1, off, sz);
	HWDATA = d;
	finish_data_phase(unused, resp);
endtask

task ahb_read(input logic [2:0] off, output logic [31:0] rdata, output hresp_e resp);
	drive_address(1'b0, off, SZ_W);
	finish_data_phase(rdata, resp);
endtask

// One LFSR step per bit taken
task take_random(output logic [31:0] w);
	for (int i = 0; i < 32; i++)
	begin
		w          = {w[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

// Register effects of a completed write
task update_model(input logic [2:0] off, input logic [2:0] sz, input logic [31:0] d);
	case (off)
		`CRC_ADDR_DR:   m_crc = ref_crc_beat(m_crc, d, sz[1:0], m_cfg, m_pol);
		`CRC_ADDR_INIT: m_init = d;
		`CRC_ADDR_POL:  m_pol = d;
		`CRC_ADDR_CR:
		begin
			m_cfg = d[7:3];
			if (d[0])
				m_crc = m_init;
		end
		default: ;
	endcase
endtask

//////////////////////////////////////////////////
// Main sequence
//////////////////////////////////////////////////

initial
begin
	test_row_t   row;
	logic [31:0] d;
	logic [31:0] rdata;
	logic [31:0] exp;
	hresp_e      resp;
	int          errs_before;
	HRESETn = 1'b0;
	HSEL    = 1'b0;
	HADDR   = '0;
	HTRANS  = IDLE;
	HWRITE  = 1'b0;
	HSIZE   = SZ_W;
	HWDATA  = '0;
	// Single slave, sampling is gated by its own HREADYOUT
	HREADY  = 1'b1;
	build_table();
	limit      = 40 * rows.size() + 100;
	lfsr_state = 16'd41061;
	m_crc      = 32'hFFFF_FFFF;
	m_init     = 32'hFFFF_FFFF;
	m_pol      = 32'h04C1_1DB7;
	m_cfg      = 5'h00;
	repeat (16) @(posedge HCLK);
	#10 HRESETn = 1'b1;
	@(posedge HCLK);
	for (int i = 0; i < rows.size(); i++)
	begin
		row         = rows[i];
		errs_before = errors;
		d           = row.data;
		if (row.rnd)
			take_random(d);
		if (row.is_write)
		begin
			ahb_write(row.offset, row.size, d, resp);
			update_model(row.offset, row.size, d);
		end
		else
		begin
			ahb_read(row.offset, rdata, resp);
			exp = row.use_ref ? ref_crc_read(m_crc, m_cfg) : row.expected;
			assert (rdata === exp)
			else
			begin
				$display("ERR %0t HRDATA reg %0d exp=%h got=%h", $time, row.offset, exp, rdata);
				errors++;
			end
		end
		assert (resp === OKAY)
		else
		begin
			$display("ERR %0t HRESP exp=%0d got=%0d", $time, OKAY, resp);
			errors++;
		end
		if (errors != errs_before)
			rows_failed++;
		$display("test %0d %s reg %0d data %h: %s", i, row.is_write ? "write" : "read ",
			row.offset, row.is_write ? d : rdata, (errors == errs_before) ? "ok" : "FAIL");
	end
	$display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
		rows.size(), rows.size() - rows_failed, rows_failed, errors);
	if (errors == 0)
		$display("All tests passed!");
	else
		$display("Test failures found");
	$finish;
end

endmodule

//--- all.f
+incdir+logic
+incdir+verif
logic/ahb_bus_pkg.sv
logic/crc_core_pkg.sv
logic/host_interface.sv
logic/crc_data_buffer.sv
logic/crc_datapath.sv
logic/crc_ahb_top.sv
verif/crc_ahb_tb.sv

//--- Bender.yml
package:
  name: crc_ahb

sources:
  # RTL in compile order
  - include_dirs:
      - logic
    files:
      - logic/ahb_bus_pkg.sv
      - logic/crc_core_pkg.sv
      - logic/host_interface.sv
      - logic/crc_data_buffer.sv
      - logic/crc_datapath.sv
      - logic/crc_ahb_top.sv
  # Testbench, top module crc_ahb_tb
  - target: test
    include_dirs:
      - logic
      - verif
    files:
      - verif/crc_ahb_tb.sv
